// ==== rtl/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

   localparam int DATA_W = 32;   // AXI4-Lite data bus width.

   // register offsets on the slave port.
   typedef enum logic [3:0] {
      REG_DATA   = 4'h0,
      REG_STATUS = 4'h4,
      REG_CTRL   = 4'h8
   } reg_addr_e;

   typedef enum logic [1:0] {
      ST_EMPTY       = 2'b00,
      ST_GOING_FULL  = 2'b01,
      ST_FULL        = 2'b11,
      ST_GOING_EMPTY = 2'b10
   } fifo_state_e;

   typedef struct packed {
      logic push_req;
      logic pop_req;
      logic flush_req;
   } fifo_req_t;

   typedef struct packed {
      logic push_en;
      logic pop_en;
      logic empty;
      logic full;
      logic err;
   } fifo_stat_t;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } resp_e;

endpackage

`default_nettype wire

// ==== rtl/fifo_ptr.sv ====
`default_nettype none
`timescale 1ns/100ps

module fifo_ptr #(
   parameter int ADDR_W = 3
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              en,
   input  logic              clr,
   output logic [ADDR_W-1:0] ptr
);

   logic [ADDR_W-1:0] ptr_nxt;

   always_comb begin
      ptr_nxt = ptr;
      if (clr) begin
         ptr_nxt = '0;                // clear wins over a step.
      end else if (en) begin
         ptr_nxt = ptr + 1'b1;        // wraps at the depth by itself.
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else begin
         ptr <= ptr_nxt;
      end
   end

   // the controller must not grant a push or pop in a clearing cycle.
   a_clr_en_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(clr && en)
   );

endmodule

`default_nettype wire

// ==== rtl/fifo_mem.sv ====
`default_nettype none
`timescale 1ns/100ps

module fifo_mem #(
   parameter int ADDR_W = 3
) (
   input  logic                        clk,
   input  logic                        wr_en,
   input  logic [ADDR_W-1:0]           wr_addr,
   input  logic [fifo_pkg::DATA_W-1:0] wr_data,
   input  logic [ADDR_W-1:0]           rd_addr,
   output logic [fifo_pkg::DATA_W-1:0] rd_data
);

   import fifo_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   assign rd_data = mem[rd_addr];  // head entry, seen before the pop lands.

endmodule

`default_nettype wire

// ==== rtl/fifo_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module fifo_ctrl #(
   parameter int ADDR_W = 3
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  fifo_pkg::fifo_req_t  req,
   input  logic [ADDR_W-1:0]    wr_ptr,
   input  logic [ADDR_W-1:0]    rd_ptr,
   output fifo_pkg::fifo_stat_t stat,
   output logic                 ptr_clr
);

   import fifo_pkg::*;

   fifo_state_e       state;
   fifo_state_e       state_nxt;
   logic              ptr_eq;
   logic [ADDR_W-1:0] wr_ptr_inc;
   logic [ADDR_W-1:0] rd_ptr_inc;

   assign ptr_eq     = (wr_ptr == rd_ptr);
   assign wr_ptr_inc = wr_ptr + 1'b1;
   assign rd_ptr_inc = rd_ptr + 1'b1;

   always_comb begin
      stat      = '0;
      ptr_clr   = 1'b0;
      state_nxt = state;

      // equal pointers mean empty or full, and the state tells which.
      case (state)
         ST_EMPTY: begin
            stat.empty = ptr_eq;
         end
         ST_FULL: begin
            stat.full = ptr_eq;
         end
         ST_GOING_FULL, ST_GOING_EMPTY: begin
            stat.empty = 1'b0;
         end
         default: begin
            stat.err = 1'b1;
            ptr_clr  = 1'b1;
         end
      endcase

      if (req.flush_req) begin
         ptr_clr = 1'b1;
      end

      stat.push_en = req.push_req & ~stat.full & ~ptr_clr;  // no grants while clearing.
      stat.pop_en  = req.pop_req & ~stat.empty & ~ptr_clr;

      if (ptr_clr) begin
         state_nxt = ST_EMPTY;
      end else if (stat.push_en && !stat.pop_en) begin
         state_nxt = (wr_ptr_inc == rd_ptr) ? ST_FULL : ST_GOING_FULL;
      end else if (stat.pop_en && !stat.push_en) begin
         state_nxt = (rd_ptr_inc == wr_ptr) ? ST_EMPTY : ST_GOING_EMPTY;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   a_no_push_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      stat.full |-> !stat.push_en
   );

   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!rst_n)
      stat.empty |-> !stat.pop_en
   );

   a_full_xor_empty: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(stat.full && stat.empty)
   );

   // Recovery from a bad state lands empty with both counters cleared.
   a_err_recover: assert property (
      @(posedge clk) disable iff (!rst_n)
      stat.err |=> (state == ST_EMPTY) && (wr_ptr == rd_ptr)
   );

endmodule

`default_nettype wire

// ==== rtl/axil_fifo_port.sv ====
`default_nettype none
`timescale 1ns/100ps

module axil_fifo_port #(
   parameter int ADDR_W = 3
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [3:0]                  awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [fifo_pkg::DATA_W-1:0] wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic                        bvalid,
   output logic [1:0]                  bresp,
   input  logic                        bready,
   input  logic [3:0]                  araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [fifo_pkg::DATA_W-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output fifo_pkg::fifo_req_t         req,
   output logic [fifo_pkg::DATA_W-1:0] wr_data,
   input  fifo_pkg::fifo_stat_t        stat,
   input  logic [ADDR_W-1:0]           wr_ptr,
   input  logic [ADDR_W-1:0]           rd_ptr,
   input  logic [fifo_pkg::DATA_W-1:0] head_data
);

   import fifo_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   logic              wr_acc;
   logic              rd_acc;
   logic [ADDR_W:0]   level;
   logic [DATA_W-1:0] status_word;
   logic [DATA_W-1:0] rd_word;
   resp_e             wr_resp;
   resp_e             rd_resp;

   // a response still waiting on its ready blocks the next accept.
   assign wr_acc  = awvalid & wvalid & ~bvalid;
   assign rd_acc  = arvalid & ~rvalid;
   assign awready = wr_acc;
   assign wready  = wr_acc;
   assign arready = rd_acc;
   assign wr_data = wdata;

   assign req.push_req  = wr_acc & (awaddr == REG_DATA);
   assign req.flush_req = wr_acc & (awaddr == REG_CTRL) & wdata[0];
   assign req.pop_req   = rd_acc & (araddr == REG_DATA);

   // equal pointers read as zero, so a full FIFO reports the depth instead.
   assign level = stat.full ? (ADDR_W + 1)'(DEPTH) : {1'b0, wr_ptr - rd_ptr};

   always_comb begin
      status_word       = '0;
      status_word[0]    = stat.empty;
      status_word[1]    = stat.full;
      status_word[2]    = stat.err;
      status_word[15:8] = 8'(level);
   end

   always_comb begin
      case (awaddr)
         REG_DATA: wr_resp = stat.push_en ? RESP_OKAY : RESP_SLVERR;
         REG_CTRL: wr_resp = RESP_OKAY;
         default:  wr_resp = RESP_SLVERR;  // status is read only.
      endcase
   end

   always_comb begin
      rd_word = '0;
      rd_resp = RESP_OKAY;
      case (araddr)
         REG_DATA: begin
            if (stat.pop_en) begin
               rd_word = head_data;
            end else begin
               rd_resp = RESP_SLVERR;   // refused pop returns zero.
            end
         end
         REG_STATUS: begin
            rd_word = status_word;
         end
         REG_CTRL: begin
            rd_word = '0;
         end
         default: begin
            rd_resp = RESP_SLVERR;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_acc) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (rd_acc) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_acc) begin
         bresp <= wr_resp;
      end
      if (rd_acc) begin
         rdata <= rd_word;
         rresp <= rd_resp;
      end
   end

   a_b_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp)
   );

   a_r_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
   );

endmodule

`default_nettype wire

// ==== rtl/fifo_periph_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module fifo_periph_top #(
   parameter int ADDR_W = 3
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [3:0]                  awaddr,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [fifo_pkg::DATA_W-1:0] wdata,
   input  logic                        wvalid,
   output logic                        wready,
   output logic                        bvalid,
   output logic [1:0]                  bresp,
   input  logic                        bready,
   input  logic [3:0]                  araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [fifo_pkg::DATA_W-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready
);

   import fifo_pkg::*;

   fifo_req_t         req;
   fifo_stat_t        stat;
   logic              ptr_clr;
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [DATA_W-1:0] wr_data;
   logic [DATA_W-1:0] head_data;

   axil_fifo_port #(.ADDR_W(ADDR_W)) port_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bvalid    (bvalid),
      .bresp     (bresp),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .req       (req),
      .wr_data   (wr_data),
      .stat      (stat),
      .wr_ptr    (wr_ptr),
      .rd_ptr    (rd_ptr),
      .head_data (head_data)
   );

   fifo_ctrl #(.ADDR_W(ADDR_W)) ctrl_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .wr_ptr  (wr_ptr),
      .rd_ptr  (rd_ptr),
      .stat    (stat),
      .ptr_clr (ptr_clr)
   );

   fifo_ptr #(.ADDR_W(ADDR_W)) wr_ptr_i (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (stat.push_en),
      .clr   (ptr_clr),
      .ptr   (wr_ptr)
   );

   fifo_ptr #(.ADDR_W(ADDR_W)) rd_ptr_i (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (stat.pop_en),
      .clr   (ptr_clr),
      .ptr   (rd_ptr)
   );

   fifo_mem #(.ADDR_W(ADDR_W)) mem_i (
      .clk     (clk),
      .wr_en   (stat.push_en),
      .wr_addr (wr_ptr),
      .wr_data (wr_data),
      .rd_addr (rd_ptr),
      .rd_data (head_data)
   );

endmodule

`default_nettype wire

// ==== verif/tb_fifo_periph.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_fifo_periph;

   import fifo_pkg::*;

   localparam int          ADDR_W    = 3;
   localparam int          DEPTH     = 2 ** ADDR_W;
   localparam int          TIMEOUT   = 200;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   typedef struct packed {
      logic              is_wr;
      logic [1:0]        resp;
      logic [DATA_W-1:0] data;
   } xact_t;

   logic              clk;
   logic              rst_n;
   logic [3:0]        awaddr;
   logic              awvalid;
   logic              awready;
   logic [DATA_W-1:0] wdata;
   logic              wvalid;
   logic              wready;
   logic              bvalid;
   logic [1:0]        bresp;
   logic              bready;
   logic [3:0]        araddr;
   logic              arvalid;
   logic              arready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   logic [31:0]       lfsr = 32'd67398;
   logic [DATA_W-1:0] model_q[$];   // words the FIFO should hold, head first.
   xact_t             exp_q[$];
   xact_t             got_q[$];
   int                errors;
   int                err_mark;
   int                tests_passed;
   int                tests_failed;

   fifo_periph_top #(.ADDR_W(ADDR_W)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        lsb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lsb  = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb) begin
            lfsr = lfsr ^ LFSR_TAPS;
         end
         val = {val[30:0], lsb};
      end
      return val;
   endfunction

   // Expected response of one access, applied to the queue model.
   function automatic xact_t predict(input logic is_wr, input logic [3:0] addr,
                                     input logic [DATA_W-1:0] data);
      xact_t x;
      x.is_wr = is_wr;
      x.resp  = RESP_OKAY;
      x.data  = '0;
      if (is_wr) begin
         if (addr == REG_DATA && model_q.size() < DEPTH) begin
            model_q.push_back(data);
         end else if (addr == REG_CTRL) begin
            if (data[0]) begin
               model_q.delete();
            end
         end else begin
            x.resp = RESP_SLVERR;       // full FIFO, status or unmapped.
         end
      end else if (addr == REG_DATA) begin
         if (model_q.size() > 0) begin
            x.data = model_q.pop_front();
         end else begin
            x.resp = RESP_SLVERR;
         end
      end else if (addr == REG_STATUS) begin
         x.data[0]    = (model_q.size() == 0);
         x.data[1]    = (model_q.size() == DEPTH);
         x.data[15:8] = 8'(model_q.size());
      end else if (addr != REG_CTRL) begin
         x.resp = RESP_SLVERR;
      end
      return x;
   endfunction

   task automatic stop_on_timeout(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $finish;
   endtask

   task automatic axi_write(input logic [3:0] addr, input logic [DATA_W-1:0] data);
      int    n;
      int    stall;
      xact_t g;
      stall = rand_bits(2);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wvalid  <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!(awready && wready) && n < TIMEOUT);
      if (!(awready && wready)) stop_on_timeout("write was never accepted by the DUT");
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      repeat (stall) @(posedge clk);   // hold off bready to stall the response.
      bready <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!bvalid && n < TIMEOUT);
      if (!bvalid) stop_on_timeout("write response never arrived");
      g.is_wr = 1'b1;
      g.resp  = bresp;
      g.data  = '0;
      bready <= 1'b0;
      got_q.push_back(g);
   endtask

   task automatic axi_read(input logic [3:0] addr);
      int    n;
      int    stall;
      xact_t g;
      stall = rand_bits(2);
      araddr  <= addr;
      arvalid <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!arready && n < TIMEOUT);
      if (!arready) stop_on_timeout("read address was never accepted by the DUT");
      arvalid <= 1'b0;
      repeat (stall) @(posedge clk);
      rready <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!rvalid && n < TIMEOUT);
      if (!rvalid) stop_on_timeout("read data never arrived");
      g.is_wr = 1'b0;
      g.resp  = rresp;
      g.data  = rdata;
      rready <= 1'b0;
      got_q.push_back(g);
   endtask

   task automatic write_reg(input logic [3:0] addr, input logic [DATA_W-1:0] data);
      exp_q.push_back(predict(1'b1, addr, data));
      axi_write(addr, data);
   endtask

   task automatic read_reg(input logic [3:0] addr);
      exp_q.push_back(predict(1'b0, addr, '0));
      axi_read(addr);
   endtask

   task automatic end_test(input string name);
      repeat (2) @(posedge clk);          // let the compare process catch up.
      if (errors == err_mark) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin : compare
      xact_t e;
      xact_t g;
      forever begin
         @(posedge clk);
         while (got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            assert (g.resp == e.resp) else begin
               $display("Error: %s got %h expected %h", e.is_wr ? "bresp" : "rresp",
                        g.resp, e.resp);
               errors++;
            end
            if (!e.is_wr) begin
               assert (g.data == e.data) else begin
                  $display("Error: rdata got %h expected %h", g.data, e.data);
                  errors++;
               end
            end
         end
      end
   end

   initial begin
      int sel;
      rst_n   <= 1'b0;
      awaddr  <= '0;
      awvalid <= 1'b0;
      wdata   <= '0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      araddr  <= '0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      read_reg(REG_STATUS);
      end_test("reset status");

      repeat (DEPTH) write_reg(REG_DATA, rand_bits(32));
      read_reg(REG_STATUS);
      repeat (DEPTH) read_reg(REG_DATA);
      read_reg(REG_STATUS);
      end_test("fill and drain");

      repeat (DEPTH) write_reg(REG_DATA, rand_bits(32));
      write_reg(REG_DATA, rand_bits(32));
      read_reg(REG_STATUS);
      repeat (DEPTH) read_reg(REG_DATA);
      end_test("push while full");

      read_reg(REG_DATA);
      read_reg(REG_STATUS);
      end_test("pop while empty");

      repeat (3) write_reg(REG_DATA, rand_bits(32));
      write_reg(REG_CTRL, 32'h1);
      read_reg(REG_STATUS);
      repeat (4) write_reg(REG_DATA, rand_bits(32));
      repeat (4) read_reg(REG_DATA);
      read_reg(REG_STATUS);
      end_test("flush");

      repeat (400) begin
         sel = rand_bits(3);
         if (sel < 3) begin
            write_reg(REG_DATA, rand_bits(32));
         end else if (sel < 6) begin
            read_reg(REG_DATA);
         end else begin
            read_reg(REG_STATUS);
         end
      end
      end_test("random mix");

      assert (exp_q.size() == 0) else begin
         $display("%0d expected responses never arrived", exp_q.size());
         errors++;
      end
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== fifo_periph.f ====
rtl/fifo_pkg.sv
rtl/fifo_ptr.sv
rtl/fifo_mem.sv
rtl/fifo_ctrl.sv
rtl/axil_fifo_port.sv
rtl/fifo_periph_top.sv
verif/tb_fifo_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f fifo_periph.f \
   --top-module tb_fifo_periph -Mdir obj_dir > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_fifo_periph > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
